// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lke_cam_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard verif/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: compile run clean

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+verif
source/lke_pkg.sv
source/cam_port_if.sv
source/cam_array.sv
source/cam_write_index.sv
source/ctrl_path_fsm.sv
source/lookup_fsm.sv
source/lke_cam_stage.sv
verif/tb_lke_cam_stage.sv

// File: source/cam_array.sv
module cam_array
    import lke_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    cam_port_if.cam cam
);

    logic [ENTRY_W-1:0]   mem [CAM_DEPTH];
    logic [CAM_DEPTH-1:0] entry_valid;
    logic [CAM_DEPTH-1:0] match_vec;

    // ==============================
    // Write side
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (cam.wr_en) begin
            entry_valid[cam.wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cam.wr_en) begin
            mem[cam.wr_addr] <= cam.wr_entry;
        end
    end

    // ==============================
    // Search side
    // ==============================
    always_comb begin
        for (int i = 0; i < CAM_DEPTH; i++) begin
            match_vec[i] = entry_valid[i] && (mem[i] == cam.search_word);
        end
    end

    // Walk downward so the lowest matching index wins
    always_comb begin
        cam.hit      = 1'b0;
        cam.hit_addr = MISS_ADDR;
        for (int i = CAM_DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                cam.hit      = 1'b1;
                cam.hit_addr = ADDR_W'(i);
            end
        end
    end

endmodule

// File: source/cam_port_if.sv
interface cam_port_if import lke_pkg::*; ();

    // Write port
    logic               wr_en;
    logic [ADDR_W-1:0]  wr_addr;
    logic [ENTRY_W-1:0] wr_entry;

    // Search port
    logic [ENTRY_W-1:0] search_word;
    logic               hit;
    logic [ADDR_W-1:0]  hit_addr;

    modport writer   (output wr_en, output wr_entry);
    modport indexer  (output wr_addr);
    modport searcher (output search_word, input hit, input hit_addr);

    modport cam (
        input  wr_en,
        input  wr_addr,
        input  wr_entry,
        input  search_word,
        output hit,
        output hit_addr
    );

endinterface

// File: source/cam_write_index.sv
module cam_write_index
    import lke_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              index_load,
    input  logic              index_step,
    input  logic [ADDR_W-1:0] index_start,
    cam_port_if.indexer       idx
);

    logic [ADDR_W-1:0] addr_q;

    // Load wins over step; the add wraps at CAM_DEPTH
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (index_load) begin
            addr_q <= index_start;
        end else if (index_step) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign idx.wr_addr = addr_q;

endmodule

// File: source/ctrl_path_fsm.sv
module ctrl_path_fsm
    import lke_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic [CTRL_W-1:0] ctrl_in_data,
    input  logic              ctrl_in_valid,
    input  logic              ctrl_in_last,

    output logic [CTRL_W-1:0] ctrl_out_data,
    output logic              ctrl_out_valid,
    output logic              ctrl_out_last,

    output logic              index_load,
    output logic              index_step,
    output logic [ADDR_W-1:0] index_start,

    cam_port_if.writer        wr
);

    ctrl_state_e         state;
    logic                first_entry;
    logic [CTRL_W-1:0]   data_swapped;
    logic [MOD_ID_W-1:0] mod_id;
    logic [RESV_W-1:0]   resv;
    logic [FLAG_W-1:0]   flag;
    logic                hdr_hit;
    logic                fwd_beat;
    logic                entry_beat;

    // ==============================
    // Header decode
    // ==============================
    assign mod_id = ctrl_in_data[MOD_ID_LSB +: MOD_ID_W];
    assign resv   = ctrl_in_data[RESV_LSB +: RESV_W];
    assign flag   = ctrl_in_data[FLAG_LSB +: FLAG_W];

    assign hdr_hit = (mod_id[MOD_ID_W-1 -: STAGE_W] == STAGE_ID)
                  && (mod_id[LOOKUP_W-1:0] == LOOKUP_ID)
                  && (resv == '0)
                  && (flag == CTRL_FLAG);

    assign fwd_beat   = ctrl_in_valid
                     && (((state == CT_IDLE) && !hdr_hit) || (state == CT_FORWARD));
    assign entry_beat = ctrl_in_valid && (state == CT_ENTRY);

    // Start index comes straight off the header beat
    assign index_start = ctrl_in_data[INDEX_LSB +: ADDR_W];
    assign index_load  = ctrl_in_valid && (state == CT_IDLE) && hdr_hit;
    assign index_step  = entry_beat && !first_entry;

    // Entry beats arrive little endian, byte 0 goes on top
    always_comb begin
        for (int b = 0; b < CTRL_W / BYTE_W; b++) begin
            data_swapped[CTRL_W-1-b*BYTE_W -: BYTE_W] = ctrl_in_data[b*BYTE_W +: BYTE_W];
        end
    end

    // ==============================
    // State and strobes
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= CT_IDLE;
            first_entry    <= 1'b0;
            wr.wr_en       <= 1'b0;
            ctrl_out_valid <= 1'b0;
            ctrl_out_last  <= 1'b0;
        end else begin
            wr.wr_en       <= entry_beat;
            ctrl_out_valid <= fwd_beat;
            ctrl_out_last  <= fwd_beat && ctrl_in_last;
            case (state)
                CT_IDLE: begin
                    if (ctrl_in_valid && !ctrl_in_last) begin
                        state <= hdr_hit ? CT_ENTRY : CT_FORWARD;
                    end
                    if (index_load) begin
                        first_entry <= 1'b1;
                    end
                end
                CT_ENTRY: begin
                    if (entry_beat) begin
                        first_entry <= 1'b0;
                        if (ctrl_in_last) begin
                            state <= CT_IDLE;
                        end
                    end
                end
                CT_FORWARD: begin
                    if (ctrl_in_valid && ctrl_in_last) begin
                        state <= CT_IDLE;
                    end
                end
                default: state <= CT_IDLE;
            endcase
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (fwd_beat) begin
            ctrl_out_data <= ctrl_in_data;
        end
        if (entry_beat) begin
            wr.wr_entry <= data_swapped[CTRL_W-1 -: ENTRY_W];
        end
    end

endmodule

// File: source/lke_cam_stage.sv
module lke_cam_stage
    import lke_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Data path in
    input  logic [KEY_W-1:0]  key,
    input  logic              key_valid,
    input  logic [PHV_W-1:0]  phv_in,
    input  logic              ready_in,

    // Data path out
    output logic              ready_out,
    output logic [PHV_W-1:0]  phv_out,
    output logic              phv_out_valid,
    output logic              if_match,
    output logic [ADDR_W-1:0] match_addr,

    // Control stream
    input  logic [CTRL_W-1:0] ctrl_in_data,
    input  logic              ctrl_in_valid,
    input  logic              ctrl_in_last,
    output logic [CTRL_W-1:0] ctrl_out_data,
    output logic              ctrl_out_valid,
    output logic              ctrl_out_last
);

    logic              index_load;
    logic              index_step;
    logic [ADDR_W-1:0] index_start;

    cam_port_if cam_bus ();

    // ==============================
    // Control path
    // ==============================
    ctrl_path_fsm ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_in_data   (ctrl_in_data),
        .ctrl_in_valid  (ctrl_in_valid),
        .ctrl_in_last   (ctrl_in_last),
        .ctrl_out_data  (ctrl_out_data),
        .ctrl_out_valid (ctrl_out_valid),
        .ctrl_out_last  (ctrl_out_last),
        .index_load     (index_load),
        .index_step     (index_step),
        .index_start    (index_start),
        .wr             (cam_bus.writer)
    );

    cam_write_index index_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .index_load  (index_load),
        .index_step  (index_step),
        .index_start (index_start),
        .idx         (cam_bus.indexer)
    );

    // ==============================
    // Lookup path
    // ==============================
    cam_array cam_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cam   (cam_bus.cam)
    );

    lookup_fsm lookup_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .key           (key),
        .key_valid     (key_valid),
        .phv_in        (phv_in),
        .ready_in      (ready_in),
        .ready_out     (ready_out),
        .phv_out       (phv_out),
        .phv_out_valid (phv_out_valid),
        .if_match      (if_match),
        .match_addr    (match_addr),
        .srch          (cam_bus.searcher)
    );

endmodule

// File: source/lke_pkg.sv
package lke_pkg;

    // ==============================
    // Data path widths
    // ==============================
    localparam int KEY_W     = 32;
    localparam int VLAN_W    = 12;
    localparam int VLAN_LSB  = 0;
    localparam int ENTRY_W   = KEY_W + VLAN_W;
    localparam int PHV_W     = 64;

    // CAM geometry
    localparam int CAM_DEPTH = 16;
    localparam int ADDR_W    = 4;
    localparam logic [ADDR_W-1:0] MISS_ADDR = '1;

    // ==============================
    // Control header layout
    // ==============================
    localparam int CTRL_W     = 64;
    localparam int BYTE_W     = 8;
    localparam int STAGE_W    = 5;
    localparam int LOOKUP_W   = 3;
    localparam int MOD_ID_W   = STAGE_W + LOOKUP_W;
    localparam int RESV_W     = 4;
    localparam int FLAG_W     = 16;
    localparam int MOD_ID_LSB = 56;
    localparam int RESV_LSB   = 52;
    localparam int FLAG_LSB   = 32;
    localparam int INDEX_LSB  = 0;

    // Identity of this stage and the table-write marker
    localparam logic [STAGE_W-1:0]  STAGE_ID  = 5'd0;
    localparam logic [LOOKUP_W-1:0] LOOKUP_ID = 3'd2;
    localparam logic [FLAG_W-1:0]   CTRL_FLAG = 16'hf2f1;

    // FSM states
    typedef enum logic [1:0] {LK_IDLE, LK_WAIT, LK_HALT} lookup_state_e;
    typedef enum logic [1:0] {CT_IDLE, CT_ENTRY, CT_FORWARD} ctrl_state_e;

endpackage

// File: source/lookup_fsm.sv
module lookup_fsm
    import lke_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic [KEY_W-1:0]  key,
    input  logic              key_valid,
    input  logic [PHV_W-1:0]  phv_in,
    input  logic              ready_in,

    output logic              ready_out,
    output logic [PHV_W-1:0]  phv_out,
    output logic              phv_out_valid,
    output logic              if_match,
    output logic [ADDR_W-1:0] match_addr,

    cam_port_if.searcher      srch
);

    lookup_state_e      state;
    logic [PHV_W-1:0]   phv_q;
    logic [ENTRY_W-1:0] search_q;
    logic [VLAN_W-1:0]  vlan_id;
    logic               take_in;
    logic               emit;

    assign vlan_id = phv_in[VLAN_LSB +: VLAN_W];

    assign take_in = key_valid && (state == LK_IDLE);
    assign emit    = ready_in && ((state == LK_WAIT) || (state == LK_HALT));

    // Only one item in flight
    assign ready_out        = (state == LK_IDLE);
    assign srch.search_word = search_q;

    // ==============================
    // State and output strobes
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= LK_IDLE;
            phv_out_valid <= 1'b0;
            if_match      <= 1'b0;
        end else begin
            phv_out_valid <= emit;
            if (emit) begin
                if_match <= srch.hit;
            end
            case (state)
                LK_IDLE: begin
                    if (take_in) begin
                        state <= LK_WAIT;
                    end
                end
                LK_WAIT: begin
                    state <= ready_in ? LK_IDLE : LK_HALT;
                end
                LK_HALT: begin
                    if (ready_in) begin
                        state <= LK_IDLE;
                    end
                end
                default: state <= LK_IDLE;
            endcase
        end
    end

    // Captured item and registered result
    always_ff @(posedge clk) begin
        if (take_in) begin
            phv_q    <= phv_in;
            // VLAN nibble order follows the table entry layout
            search_q <= {vlan_id[3:0], vlan_id[VLAN_W-1:4], key};
        end
        if (emit) begin
            phv_out    <= phv_q;
            match_addr <= srch.hit_addr;
        end
    end

endmodule

// File: verif/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// Columns: is_ctrl, mod_id, resv, flag, start, count, key_sel, vlan, stall, exp_hit, exp_addr
// Control rows send count beats after the header; lookups search key_pool[key_sel] and vlan
localparam int N_CASES = 20;

case_t cases [N_CASES];

task automatic load_case_table();
    // Three entries at 5, 6 and 7, one lookup each, then a miss
    cases[0]  = '{1'b1, 8'h02, 4'h0, 16'hf2f1, 4'd5, 4'd3, 4'd0, 12'h123, 4'd0, 1'b0, 4'd0};
    cases[1]  = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd0, 12'h123, 4'd0, 1'b1, 4'd5};
    cases[2]  = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd1, 12'h124, 4'd0, 1'b1, 4'd6};
    cases[3]  = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd2, 12'h125, 4'd0, 1'b1, 4'd7};
    cases[4]  = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd3, 12'h200, 4'd0, 1'b0, 4'd15};
    // Same entry at 9 and 2, lower index wins
    cases[5]  = '{1'b1, 8'h02, 4'h0, 16'hf2f1, 4'd9, 4'd1, 4'd4, 12'h300, 4'd0, 1'b0, 4'd0};
    cases[6]  = '{1'b1, 8'h02, 4'h0, 16'hf2f1, 4'd2, 4'd1, 4'd4, 12'h300, 4'd0, 1'b0, 4'd0};
    cases[7]  = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd4, 12'h300, 4'd0, 1'b1, 4'd2};
    // Foreign packets: wrong stage, wrong flag, nonzero resv
    cases[8]  = '{1'b1, 8'h0a, 4'h0, 16'hf2f1, 4'd0, 4'd2, 4'd5, 12'h040, 4'd0, 1'b0, 4'd0};
    cases[9]  = '{1'b1, 8'h02, 4'h0, 16'hf2f0, 4'd0, 4'd2, 4'd5, 12'h040, 4'd0, 1'b0, 4'd0};
    cases[10] = '{1'b1, 8'h02, 4'h1, 16'hf2f1, 4'd0, 4'd2, 4'd5, 12'h040, 4'd0, 1'b0, 4'd0};
    cases[11] = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd5, 12'h040, 4'd0, 1'b0, 4'd15};
    // Back-pressure on a hit and on a miss
    cases[12] = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd0, 12'h123, 4'd4, 1'b1, 4'd5};
    cases[13] = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd3, 12'h200, 4'd2, 1'b0, 4'd15};
    // Entry at 0, then overwritten by a packet wrapping from 15
    cases[14] = '{1'b1, 8'h02, 4'h0, 16'hf2f1, 4'd0, 4'd1, 4'd6, 12'h0ab, 4'd0, 1'b0, 4'd0};
    cases[15] = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd6, 12'h0ab, 4'd0, 1'b1, 4'd0};
    cases[16] = '{1'b1, 8'h02, 4'h0, 16'hf2f1, 4'd15, 4'd2, 4'd7, 12'h777, 4'd0, 1'b0, 4'd0};
    cases[17] = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd6, 12'h0ab, 4'd0, 1'b0, 4'd15};
    cases[18] = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd8, 12'h778, 4'd0, 1'b1, 4'd0};
    cases[19] = '{1'b0, 8'h00, 4'h0, 16'h0000, 4'd0, 4'd0, 4'd7, 12'h777, 4'd0, 1'b1, 4'd15};
endtask

`endif

// File: verif/tb_lke_cam_stage.sv
module tb_lke_cam_stage
    import lke_pkg::*;
();

    localparam int CLK_PERIOD = 40;

    // One operation: a control packet or a lookup
    typedef struct packed {
        logic              is_ctrl;
        logic [7:0]        mod_id;
        logic [3:0]        resv;
        logic [15:0]       flag;
        logic [ADDR_W-1:0] start;
        logic [3:0]        count;
        logic [3:0]        key_sel;
        logic [VLAN_W-1:0] vlan;
        logic [3:0]        stall;
        logic              exp_hit;
        logic [ADDR_W-1:0] exp_addr;
    } case_t;

    logic              clk;
    logic              rst_n;
    logic [KEY_W-1:0]  key;
    logic              key_valid;
    logic [PHV_W-1:0]  phv_in;
    logic              ready_in;
    logic              ready_out;
    logic [PHV_W-1:0]  phv_out;
    logic              phv_out_valid;
    logic              if_match;
    logic [ADDR_W-1:0] match_addr;
    logic [CTRL_W-1:0] ctrl_in_data;
    logic              ctrl_in_valid;
    logic              ctrl_in_last;
    logic [CTRL_W-1:0] ctrl_out_data;
    logic              ctrl_out_valid;
    logic              ctrl_out_last;

    // Test state and CAM model
    logic [KEY_W-1:0]   key_pool [16];
    logic [ENTRY_W-1:0] model_entry [CAM_DEPTH];
    logic               model_valid [CAM_DEPTH];
    int                 seed;
    int                 row_errors;
    int                 pass_count;
    int                 fail_count;
    int                 lookups;
    int                 pulses;

    `include "tb_cases.svh"

    lke_cam_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * 50 * N_CASES);
        $display("Watchdog expired before all %0d rows finished, run stopped", N_CASES);
        $display("TESTS FAILED");
        $finish;
    end

    // Single-cycle pulses, so one sample per cycle counts each once
    always @(negedge clk) begin
        if (rst_n === 1'b1 && phv_out_valid === 1'b1)
            pulses++;
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        row_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        row_errors++;
    endtask

    task automatic tally_row(input string name);
        if (row_errors == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d error(s)", name, row_errors);
        end
    endtask

    // VLAN low nibble on top, then upper 8 bits, then the key
    function automatic logic [ENTRY_W-1:0] search_word_of(input logic [KEY_W-1:0] k,
                                                          input logic [VLAN_W-1:0] v);
        return {v[3:0], v[VLAN_W-1:4], k};
    endfunction

    function automatic logic [CTRL_W-1:0] reverse_bytes(input logic [CTRL_W-1:0] d);
        logic [CTRL_W-1:0] r;
        for (int b = 0; b < CTRL_W / 8; b++)
            r[CTRL_W-1-8*b -: 8] = d[8*b +: 8];
        return r;
    endfunction

    function automatic logic [CTRL_W-1:0] header_word(input case_t c);
        return {c.mod_id, c.resv, 4'h0, c.flag, 24'h0, 4'h0, c.start};
    endfunction

    // ==============================
    // Control packet driver
    // ==============================
    task automatic send_ctrl(input case_t c);
        logic [CTRL_W-1:0]  beats [$];
        logic [ENTRY_W-1:0] word;
        logic [31:0]        filler;
        logic               forward;
        logic               last_out;
        int                 idx;

        forward = !((c.mod_id == {STAGE_ID, LOOKUP_ID}) && (c.resv == 4'h0)
                    && (c.flag == CTRL_FLAG));
        idx = int'(c.start);
        beats.push_back(header_word(c));
        for (int k = 0; k < int'(c.count); k++) begin
            filler = $random(seed);
            word   = search_word_of(key_pool[int'(c.key_sel) + k], c.vlan + VLAN_W'(k));
            beats.push_back(reverse_bytes({word, filler[CTRL_W-ENTRY_W-1:0]}));
            if (!forward) begin
                model_entry[idx] = word;
                model_valid[idx] = 1'b1;
                idx = (idx + 1) % CAM_DEPTH;
            end
        end
        // Each beat shows up on the output one cycle after it goes in
        for (int i = 0; i <= beats.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                last_out = (i == beats.size());
                if (ctrl_out_valid !== forward)
                    report_mismatch($sformatf("ctrl_out_valid %b, expected %b",
                                              ctrl_out_valid, forward));
                else if (forward && (ctrl_out_data !== beats[i-1] || ctrl_out_last !== last_out))
                    report_mismatch($sformatf("ctrl beat %0d is %h last %b, expected %h last %b",
                                              i - 1, ctrl_out_data, ctrl_out_last,
                                              beats[i-1], last_out));
            end
            ctrl_in_valid = (i < beats.size());
            ctrl_in_last  = (i == beats.size() - 1);
            ctrl_in_data  = (i < beats.size()) ? beats[i] : '0;
        end
    endtask

    // ==============================
    // Lookup driver and checks
    // ==============================
    task automatic do_lookup(input case_t c);
        logic [PHV_W-1:0]   phv;
        logic [ENTRY_W-1:0] word;
        logic               want_hit;
        logic [ADDR_W-1:0]  want_addr;
        int                 waited;

        phv = {$random(seed), $random(seed)};
        phv[VLAN_LSB +: VLAN_W] = c.vlan;
        word = search_word_of(key_pool[c.key_sel], c.vlan);
        want_hit  = 1'b0;
        want_addr = MISS_ADDR;
        for (int i = 0; i < CAM_DEPTH; i++) begin
            if (!want_hit && model_valid[i] && model_entry[i] == word) begin
                want_hit  = 1'b1;
                want_addr = ADDR_W'(i);
            end
        end
        if (want_hit !== c.exp_hit || want_addr !== c.exp_addr)
            note_failure($sformatf("table row disagrees with the CAM model (hit %b at %0d)",
                                   want_hit, want_addr));
        @(negedge clk);
        if (ready_out !== 1'b1)
            note_failure("ready_out was low when a new lookup was due");
        key       = key_pool[c.key_sel];
        phv_in    = phv;
        key_valid = 1'b1;
        ready_in  = (c.stall == 4'd0);
        lookups++;
        @(negedge clk);
        key_valid = 1'b0;
        for (int s = 0; s < int'(c.stall); s++) begin
            if (ready_out !== 1'b0 || phv_out_valid !== 1'b0)
                report_mismatch($sformatf("stalled with ready_out %b phv_out_valid %b",
                                          ready_out, phv_out_valid));
            @(negedge clk);
        end
        ready_in = 1'b1;
        waited   = 0;
        while (phv_out_valid !== 1'b1 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (phv_out_valid !== 1'b1) begin
            note_failure("no phv_out_valid pulse came back for the lookup");
        end else begin
            if (if_match !== c.exp_hit)
                report_mismatch($sformatf("if_match %b, expected %b", if_match, c.exp_hit));
            if (match_addr !== c.exp_addr)
                report_mismatch($sformatf("match_addr %0d, expected %0d", match_addr, c.exp_addr));
            if (phv_out !== phv)
                report_mismatch($sformatf("phv_out %h, expected %h", phv_out, phv));
        end
        @(negedge clk);
        if (phv_out_valid !== 1'b0)
            note_failure("phv_out_valid stayed high for more than one cycle");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        seed          = 32'ha3c7_2d51;
        rst_n         = 1'b0;
        key           = '0;
        key_valid     = 1'b0;
        phv_in        = '0;
        ready_in      = 1'b1;
        ctrl_in_data  = '0;
        ctrl_in_valid = 1'b0;
        ctrl_in_last  = 1'b0;
        pass_count    = 0;
        fail_count    = 0;
        lookups       = 0;
        pulses        = 0;
        for (int i = 0; i < 16; i++)
            key_pool[i] = $random(seed);
        for (int i = 0; i < CAM_DEPTH; i++) begin
            model_entry[i] = '0;
            model_valid[i] = 1'b0;
        end
        load_case_table();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n      = 1'b1;
        row_errors = 0;
        if (ready_out !== 1'b1 || phv_out_valid !== 1'b0 || ctrl_out_valid !== 1'b0)
            report_mismatch($sformatf("after reset ready_out %b phv_out_valid %b ctrl_out_valid %b",
                                      ready_out, phv_out_valid, ctrl_out_valid));
        tally_row("Reset values");

        for (int r = 0; r < N_CASES; r++) begin
            row_errors = 0;
            if (cases[r].is_ctrl)
                send_ctrl(cases[r]);
            else
                do_lookup(cases[r]);
            tally_row($sformatf("Row %0d %s", r, cases[r].is_ctrl ? "control" : "lookup"));
        end

        repeat (2) @(negedge clk);
        row_errors = 0;
        if (pulses != lookups)
            report_mismatch($sformatf("%0d phv_out_valid pulses for %0d lookups", pulses, lookups));
        tally_row("Pulse count");

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
